/* bp_delta.f */
source/bp_fixed_pkg.sv
source/bp_net_pkg.sv
source/bp_unit_if.sv
source/bp_output_error.sv
source/bp_hidden_accum.sv
source/bp_leaky_derivative.sv
source/bp_layer_sequencer.sv
source/bp_delta_top.sv
sim/bp_delta_checker.sv
sim/bp_delta_tb.sv

/* Makefile */
# Verilator build and run of the backprop delta testbench.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
		-f bp_delta.f --top-module bp_delta_tb
	./obj_dir/Vbp_delta_tb | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/bp_delta_tb.sv */
`timescale 1ns/1ps

module bp_delta_tb;

	logic clk;
	logic rst_n;
	logic i_data_valid;
	logic signed [bp_fixed_pkg::word_w-1:0] i_data_expected;
	logic signed [bp_fixed_pkg::word_w-1:0] i_data_node;
	logic i_weight_valid;
	logic signed [bp_fixed_pkg::word_w-1:0] i_weight;
	logic [bp_net_pkg::layer_w-1:0] o_current_layer;
	logic o_weight_valid;
	logic [bp_net_pkg::addr_w-1:0] o_delta_addr;
	logic signed [bp_fixed_pkg::word_w-1:0] o_delta;
	logic o_delta_valid;

	// one sample, weights indexed as [node][source node].
	logic signed [bp_fixed_pkg::word_w-1:0] target [bp_net_pkg::n_out];
	logic signed [bp_fixed_pkg::word_w-1:0] act_out [bp_net_pkg::n_out];
	logic signed [bp_fixed_pkg::word_w-1:0] act_h2 [bp_net_pkg::n_hid2];
	logic signed [bp_fixed_pkg::word_w-1:0] act_h1 [bp_net_pkg::n_hid1];
	logic signed [bp_fixed_pkg::word_w-1:0] w_h2 [bp_net_pkg::n_hid2][bp_net_pkg::n_out];
	logic signed [bp_fixed_pkg::word_w-1:0] w_h1 [bp_net_pkg::n_hid1][bp_net_pkg::n_hid2];

	int exp_layer [$];
	int exp_addr [$];
	int exp_value [$];
	int run_count = 8;
	bit run_closed;
	logic [bp_net_pkg::layer_w-1:0] prev_layer;

	bp_delta_top UUT (.*);

	always #20 clk = ~clk;

	task automatic stop_run(input string reason);
		run_closed = 1'b1;
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	function automatic int clamp_word(input int value);
		if (value > int'(bp_fixed_pkg::word_max)) return int'(bp_fixed_pkg::word_max);
		if (value < int'(bp_fixed_pkg::word_min)) return int'(bp_fixed_pkg::word_min);
		return value;
	endfunction

	// slope alpha applies to negative activations.
	function automatic int leaky_scale(input int raw, input int act);
		if (act < 0) return raw >>> bp_fixed_pkg::alpha_shift;
		return raw;
	endfunction

	function automatic logic signed [15:0] draw_target();
		case ($urandom_range(0, 3))
			0: return bp_fixed_pkg::word_max;
			1: return bp_fixed_pkg::word_min;
			default: return 16'($urandom);
		endcase
	endfunction

	// weights stay within about +-2.0 so that not every sum saturates.
	function automatic logic signed [15:0] draw_weight();
		return 16'(int'($urandom_range(0, 16383)) - 8192);
	endfunction

	task automatic queue_delta(input int layer, input int addr, input int value);
		exp_layer.push_back(layer);
		exp_addr.push_back(addr);
		exp_value.push_back(value);
	endtask

	task automatic build_expected();
		int d_out [bp_net_pkg::n_out];
		int d_h2 [bp_net_pkg::n_hid2];
		int sum;
		for (int k = 0; k < bp_net_pkg::n_out; k++) begin
			d_out[k] = leaky_scale(clamp_word(int'(target[k]) - int'(act_out[k])),
				int'(act_out[k]));
			queue_delta(bp_net_pkg::layer_output, k, d_out[k]);
		end
		// each product drops its extra fraction bits before it is summed.
		for (int j = 0; j < bp_net_pkg::n_hid2; j++) begin
			sum = 0;
			for (int k = 0; k < bp_net_pkg::n_out; k++) begin
				sum += (d_out[k] * int'(w_h2[j][k])) >>> bp_fixed_pkg::frac_w;
			end
			d_h2[j] = leaky_scale(clamp_word(sum), int'(act_h2[j]));
			queue_delta(bp_net_pkg::layer_hid2, j, d_h2[j]);
		end
		for (int i = 0; i < bp_net_pkg::n_hid1; i++) begin
			sum = 0;
			for (int j = 0; j < bp_net_pkg::n_hid2; j++) begin
				sum += (d_h2[j] * int'(w_h1[i][j])) >>> bp_fixed_pkg::frac_w;
			end
			queue_delta(bp_net_pkg::layer_hid1, i,
				leaky_scale(clamp_word(sum), int'(act_h1[i])));
		end
	endtask

	// stray burst words that the core has to ignore.
	task automatic drive_noise();
		i_data_valid = 1'($urandom_range(0, 1));
		i_data_expected = 16'($urandom);
		i_data_node = 16'($urandom);
	endtask

	task automatic wait_weight_request();
		while (!o_weight_valid) begin
			drive_noise();
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_weight(input logic signed [15:0] weight);
		int gap;
		gap = $urandom_range(0, 3);
		repeat (gap) begin
			drive_noise();
			@(posedge clk);
			#2;
		end
		drive_noise();
		i_weight_valid = 1'b1;
		i_weight = weight;
		@(posedge clk);
		#2;
		i_weight_valid = 1'b0;
	endtask

	task automatic run_sample();
		for (int k = 0; k < bp_net_pkg::n_out; k++) begin
			target[k] = draw_target();
			act_out[k] = 16'($urandom);
		end
		for (int j = 0; j < bp_net_pkg::n_hid2; j++) begin
			act_h2[j] = 16'($urandom);
			for (int k = 0; k < bp_net_pkg::n_out; k++) begin
				w_h2[j][k] = draw_weight();
			end
		end
		for (int i = 0; i < bp_net_pkg::n_hid1; i++) begin
			act_h1[i] = 16'($urandom);
			for (int j = 0; j < bp_net_pkg::n_hid2; j++) begin
				w_h1[i][j] = draw_weight();
			end
		end
		build_expected();
		for (int n = 0; n < bp_net_pkg::n_sample; n++) begin
			assert (o_current_layer == bp_net_pkg::layer_input)
			else stop_run("a burst word was offered while the core was busy");
			i_data_valid = 1'b1;
			if (n < bp_net_pkg::n_out) begin
				i_data_expected = target[n];
				i_data_node = act_out[n];
			end else if (n < bp_net_pkg::n_out + bp_net_pkg::n_hid2) begin
				i_data_expected = 16'($urandom);
				i_data_node = act_h2[n - bp_net_pkg::n_out];
			end else begin
				i_data_node = act_h1[n - bp_net_pkg::n_out - bp_net_pkg::n_hid2];
			end
			@(posedge clk);
			#2;
		end
		// the first idle cycle closes the burst.
		i_data_valid = 1'b0;
		@(posedge clk);
		#2;
		wait_weight_request();
		for (int j = 0; j < bp_net_pkg::n_hid2; j++) begin
			for (int k = 0; k < bp_net_pkg::n_out; k++) begin
				send_weight(w_h2[j][k]);
			end
		end
		wait_weight_request();
		for (int i = 0; i < bp_net_pkg::n_hid1; i++) begin
			for (int j = 0; j < bp_net_pkg::n_hid2; j++) begin
				send_weight(w_h1[i][j]);
			end
		end
		i_data_valid = 1'b0;
		while (o_current_layer != bp_net_pkg::layer_input) begin
			@(posedge clk);
			#2;
		end
		assert (exp_value.size() == 0)
		else stop_run("a sample finished with expected deltas still missing");
	endtask

	// outputs are sampled half a cycle away from the active edge.
	always @(negedge clk) begin
		if (rst_n && o_delta_valid) begin
			if (exp_value.size() == 0) begin
				stop_run("a delta came out that the model did not expect");
			end else begin
				assert (o_delta_addr == exp_addr[0] && o_current_layer == exp_layer[0] &&
					o_delta == exp_value[0]) begin
					void'(exp_layer.pop_front());
					void'(exp_addr.pop_front());
					void'(exp_value.pop_front());
				end else begin
					stop_run($sformatf(
						"Error: %0t ns: layer %0d addr %0d value %0d, expected %0d %0d %0d",
						$time, o_current_layer, o_delta_addr, o_delta,
						exp_layer[0], exp_addr[0], exp_value[0]));
				end
			end
		end
	end

	// the layer only ever steps back by one, 0 wrapping to 3.
	always @(negedge clk) begin
		if (rst_n && o_current_layer != prev_layer) begin
			assert (o_current_layer == prev_layer - 1'b1)
			else stop_run("the layer code left the order 3, 2, 1, 0");
		end
	end

	always @(negedge clk) begin
		prev_layer <= o_current_layer;
	end

	initial begin
		int limit;
		limit = run_count * (bp_net_pkg::n_sample + 4 * (bp_net_pkg::n_out * bp_net_pkg::n_hid2 +
			bp_net_pkg::n_hid2 * bp_net_pkg::n_hid1) + 20) + 16;
		repeat (limit) @(posedge clk);
		stop_run("the watchdog expired before all samples were processed");
	end

	// an assertion in the bound checker can end the run early.
	final begin
		if (!run_closed) $display("SIMULATION FAILED");
	end

	initial begin
		void'($urandom(32'hf367_b0f5));
		clk = 1'b0;
		rst_n = 1'b0;
		i_data_valid = 1'b0;
		i_data_expected = '0;
		i_data_node = '0;
		i_weight_valid = 1'b0;
		i_weight = '0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		assert (o_current_layer == bp_net_pkg::layer_input && !o_weight_valid && !o_delta_valid)
		else stop_run("the outputs were not idle after reset");
		for (int s = 0; s < run_count; s++) begin
			run_sample();
		end
		run_closed = 1'b1;
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* sim/bp_delta_checker.sv */
`timescale 1ns/1ps

module bp_delta_checker (
	input logic clk,
	input logic rst_n,
	input logic [bp_net_pkg::layer_w-1:0] i_current_layer,
	input logic i_weight_valid,
	input logic [bp_net_pkg::addr_w-1:0] i_delta_addr,
	input logic i_delta_valid
);

	logic [bp_net_pkg::addr_w:0] layer_size;

	// node count of the layer being worked on.
	always_comb begin
		case (i_current_layer)
			bp_net_pkg::layer_output: layer_size = $bits(layer_size)'(bp_net_pkg::n_out);
			bp_net_pkg::layer_hid2: layer_size = $bits(layer_size)'(bp_net_pkg::n_hid2);
			bp_net_pkg::layer_hid1: layer_size = $bits(layer_size)'(bp_net_pkg::n_hid1);
			default: layer_size = '0;
		endcase
	end

	weight_pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
		i_weight_valid |=> !i_weight_valid)
		else $error("weight request held for more than one cycle");

	// a request comes only as the layer steps into hidden-2 or hidden-1.
	weight_pulse_entry: assert property (@(posedge clk) disable iff (!rst_n)
		i_weight_valid |-> ((i_current_layer == bp_net_pkg::layer_hid2) ||
			(i_current_layer == bp_net_pkg::layer_hid1)) &&
			(i_current_layer != $past(i_current_layer)))
		else $error("weight request outside the entry of a hidden layer");

	delta_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
		i_delta_valid |-> (i_delta_addr < layer_size))
		else $error("delta address beyond the size of its layer");

	no_delta_at_input: assert property (@(posedge clk) disable iff (!rst_n)
		i_delta_valid |-> (i_current_layer != bp_net_pkg::layer_input))
		else $error("delta strobe while the core sits in the input layer");

endmodule

bind bp_delta_top bp_delta_checker u_checker (
	.clk             (clk),
	.rst_n           (rst_n),
	.i_current_layer (o_current_layer),
	.i_weight_valid  (o_weight_valid),
	.i_delta_addr    (o_delta_addr),
	.i_delta_valid   (o_delta_valid)
);

/* source/bp_delta_top.sv */
`timescale 1ns/1ps

module bp_delta_top (
	input  logic clk,
	input  logic rst_n,
	input  logic i_data_valid,
	input  logic signed [bp_fixed_pkg::word_w-1:0] i_data_expected,
	input  logic signed [bp_fixed_pkg::word_w-1:0] i_data_node,
	input  logic i_weight_valid,
	input  logic signed [bp_fixed_pkg::word_w-1:0] i_weight,
	output logic [bp_net_pkg::layer_w-1:0] o_current_layer,
	output logic o_weight_valid,
	output logic [bp_net_pkg::addr_w-1:0] o_delta_addr,
	output logic signed [bp_fixed_pkg::word_w-1:0] o_delta,
	output logic o_delta_valid
);

	bp_unit_if err_if ();
	bp_unit_if h2_if ();
	bp_unit_if h1_if ();
	bp_unit_if lr_if ();

	bp_layer_sequencer u_sequencer (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_data_valid    (i_data_valid),
		.i_data_expected (i_data_expected),
		.i_data_node     (i_data_node),
		.i_weight_valid  (i_weight_valid),
		.i_weight        (i_weight),
		.o_current_layer (o_current_layer),
		.o_weight_valid  (o_weight_valid),
		.o_delta_addr    (o_delta_addr),
		.o_delta         (o_delta),
		.o_delta_valid   (o_delta_valid),
		.err_if          (err_if.seq),
		.h2_if           (h2_if.seq),
		.h1_if           (h1_if.seq),
		.lr_if           (lr_if.seq)
	);

	bp_output_error u_output_error (.clk(clk), .rst_n(rst_n), .u(err_if.unit));

	// hidden-2 nodes sum over the outputs, hidden-1 nodes over hidden-2.
	bp_hidden_accum #(.fan_out(bp_net_pkg::n_out)) u_h2_accum (
		.clk   (clk),
		.rst_n (rst_n),
		.u     (h2_if.unit)
	);

	bp_hidden_accum #(.fan_out(bp_net_pkg::n_hid2)) u_h1_accum (
		.clk   (clk),
		.rst_n (rst_n),
		.u     (h1_if.unit)
	);

	bp_leaky_derivative u_leaky (.clk(clk), .rst_n(rst_n), .u(lr_if.unit));

endmodule

/* source/bp_layer_sequencer.sv */
`timescale 1ns/1ps

module bp_layer_sequencer (
	input  logic clk,
	input  logic rst_n,
	input  logic i_data_valid,
	input  logic signed [bp_fixed_pkg::word_w-1:0] i_data_expected,
	input  logic signed [bp_fixed_pkg::word_w-1:0] i_data_node,
	input  logic i_weight_valid,
	input  logic signed [bp_fixed_pkg::word_w-1:0] i_weight,
	output logic [bp_net_pkg::layer_w-1:0] o_current_layer,
	output logic o_weight_valid,
	output logic [bp_net_pkg::addr_w-1:0] o_delta_addr,
	output logic signed [bp_fixed_pkg::word_w-1:0] o_delta,
	output logic o_delta_valid,
	bp_unit_if.seq err_if,
	bp_unit_if.seq h2_if,
	bp_unit_if.seq h1_if,
	bp_unit_if.seq lr_if
);

	// sample buffers.
	logic signed [bp_fixed_pkg::word_w-1:0] target_buf [bp_net_pkg::n_out];
	logic signed [bp_fixed_pkg::word_w-1:0] act_out [bp_net_pkg::n_out];
	logic signed [bp_fixed_pkg::word_w-1:0] act_h2 [bp_net_pkg::n_hid2];
	logic signed [bp_fixed_pkg::word_w-1:0] act_h1 [bp_net_pkg::n_hid1];

	// deltas that feed the next layer back.
	logic signed [bp_fixed_pkg::word_w-1:0] delta_out [bp_net_pkg::n_out];
	logic signed [bp_fixed_pkg::word_w-1:0] delta_h2 [bp_net_pkg::n_hid2];

	logic [bp_net_pkg::sample_w-1:0] data_cnt;
	logic [bp_net_pkg::sample_w-1:0] h2_slot;
	logic [bp_net_pkg::sample_w-1:0] h1_slot;
	logic [bp_net_pkg::addr_w:0] issue_cnt;
	logic [bp_net_pkg::addr_w-1:0] weight_idx;
	logic [bp_net_pkg::addr_w-1:0] weight_last;
	logic [bp_net_pkg::addr_w-1:0] term_cnt;
	logic [bp_net_pkg::addr_w-1:0] delta_cnt;
	logic [bp_net_pkg::addr_w-1:0] delta_last;
	logic raw_valid;
	logic signed [bp_fixed_pkg::word_w-1:0] raw_term;
	logic signed [bp_fixed_pkg::word_w-1:0] raw_act;

	always_comb begin
		h2_slot = data_cnt - bp_net_pkg::sample_w'(bp_net_pkg::n_out);
		h1_slot = data_cnt - bp_net_pkg::sample_w'(bp_net_pkg::n_out + bp_net_pkg::n_hid2);
		// hidden-2 sums run over the output deltas, hidden-1 over hidden-2.
		if (o_current_layer == bp_net_pkg::layer_hid2) begin
			weight_last = bp_net_pkg::addr_w'(bp_net_pkg::n_out - 1);
		end else begin
			weight_last = bp_net_pkg::addr_w'(bp_net_pkg::n_hid2 - 1);
		end
		case (o_current_layer)
			bp_net_pkg::layer_output: delta_last = bp_net_pkg::addr_w'(bp_net_pkg::n_out - 1);
			bp_net_pkg::layer_hid2: delta_last = bp_net_pkg::addr_w'(bp_net_pkg::n_hid2 - 1);
			default: delta_last = bp_net_pkg::addr_w'(bp_net_pkg::n_hid1 - 1);
		endcase
	end

	// error operations go out back to back in layer 3.
	assign err_if.valid = (o_current_layer == bp_net_pkg::layer_output) &&
		(issue_cnt < bp_net_pkg::n_out);
	assign err_if.operand_a = target_buf[issue_cnt[bp_net_pkg::addr_w-1:0]];
	assign err_if.operand_b = act_out[issue_cnt[bp_net_pkg::addr_w-1:0]];

	// each weight is paired with the delta of its source node.
	assign h2_if.valid = (o_current_layer == bp_net_pkg::layer_hid2) && i_weight_valid;
	assign h2_if.operand_a = delta_out[weight_idx];
	assign h2_if.operand_b = i_weight;
	assign h1_if.valid = (o_current_layer == bp_net_pkg::layer_hid1) && i_weight_valid;
	assign h1_if.operand_a = delta_h2[weight_idx];
	assign h1_if.operand_b = i_weight;

	// raw term of the active layer meets the activation of its node.
	always_comb begin
		raw_valid = err_if.result_valid | h2_if.result_valid | h1_if.result_valid;
		case (o_current_layer)
			bp_net_pkg::layer_output: begin
				raw_term = err_if.result;
				raw_act = act_out[term_cnt];
			end
			bp_net_pkg::layer_hid2: begin
				raw_term = h2_if.result;
				raw_act = act_h2[term_cnt];
			end
			default: begin
				raw_term = h1_if.result;
				raw_act = act_h1[term_cnt];
			end
		endcase
	end

	assign lr_if.valid = raw_valid;
	assign lr_if.operand_a = raw_term;
	assign lr_if.operand_b = raw_act;

	assign o_delta = lr_if.result;
	assign o_delta_valid = lr_if.result_valid;
	assign o_delta_addr = delta_cnt;

	// burst words land in the buffer of their layer.
	always_ff @(posedge clk) begin
		if (o_current_layer == bp_net_pkg::layer_input && i_data_valid) begin
			if (data_cnt < bp_net_pkg::sample_w'(bp_net_pkg::n_out)) begin
				target_buf[data_cnt[bp_net_pkg::addr_w-1:0]] <= i_data_expected;
				act_out[data_cnt[bp_net_pkg::addr_w-1:0]] <= i_data_node;
			end else if (data_cnt < bp_net_pkg::sample_w'(bp_net_pkg::n_out + bp_net_pkg::n_hid2)) begin
				act_h2[h2_slot[bp_net_pkg::addr_w-1:0]] <= i_data_node;
			end else if (data_cnt < bp_net_pkg::sample_w'(bp_net_pkg::n_sample)) begin
				act_h1[h1_slot[bp_net_pkg::addr_w-1:0]] <= i_data_node;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lr_if.result_valid) begin
			if (o_current_layer == bp_net_pkg::layer_output) begin
				delta_out[delta_cnt] <= lr_if.result;
			end else if (o_current_layer == bp_net_pkg::layer_hid2) begin
				delta_h2[delta_cnt] <= lr_if.result;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_current_layer <= bp_net_pkg::layer_input;
			o_weight_valid <= 1'b0;
			data_cnt <= '0;
			issue_cnt <= '0;
			weight_idx <= '0;
			term_cnt <= '0;
			delta_cnt <= '0;
		end else begin
			o_weight_valid <= 1'b0;
			case (o_current_layer)
				bp_net_pkg::layer_input: begin
					if (i_data_valid) begin
						if (data_cnt < bp_net_pkg::sample_w'(bp_net_pkg::n_sample)) begin
							data_cnt <= data_cnt + 1'b1;
						end
					end else if (data_cnt == bp_net_pkg::sample_w'(bp_net_pkg::n_sample)) begin
						data_cnt <= '0;
						o_current_layer <= bp_net_pkg::layer_output;
					end
				end
				bp_net_pkg::layer_output: begin
					if (err_if.valid) begin
						issue_cnt <= issue_cnt + 1'b1;
					end
				end
				default: begin
					if (i_weight_valid) begin
						weight_idx <= (weight_idx == weight_last) ? '0 : weight_idx + 1'b1;
					end
				end
			endcase

			if (raw_valid) begin
				term_cnt <= term_cnt + 1'b1;
			end

			// the last delta of a layer moves the state one layer back.
			if (lr_if.result_valid) begin
				if (delta_cnt == delta_last) begin
					delta_cnt <= '0;
					term_cnt <= '0;
					issue_cnt <= '0;
					weight_idx <= '0;
					case (o_current_layer)
						bp_net_pkg::layer_output: begin
							o_current_layer <= bp_net_pkg::layer_hid2;
							o_weight_valid <= 1'b1;
						end
						bp_net_pkg::layer_hid2: begin
							o_current_layer <= bp_net_pkg::layer_hid1;
							o_weight_valid <= 1'b1;
						end
						default: o_current_layer <= bp_net_pkg::layer_input;
					endcase
				end else begin
					delta_cnt <= delta_cnt + 1'b1;
				end
			end
		end
	end

endmodule

/* source/bp_leaky_derivative.sv */
`timescale 1ns/1ps

module bp_leaky_derivative (
	input logic clk,
	input logic rst_n,
	bp_unit_if.unit u
);

	logic negative_act;

	// derivative is 1 for a non-negative activation, alpha otherwise.
	always_comb begin
		negative_act = u.operand_b[bp_fixed_pkg::word_w-1];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			u.result_valid <= 1'b0;
		end else begin
			u.result_valid <= u.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (u.valid) begin
			if (negative_act) begin
				u.result <= u.operand_a >>> bp_fixed_pkg::alpha_shift;
			end else begin
				u.result <= u.operand_a;
			end
		end
	end

endmodule

/* source/bp_hidden_accum.sv */
`timescale 1ns/1ps

module bp_hidden_accum #(
	parameter int fan_out = 4
) (
	input logic clk,
	input logic rst_n,
	bp_unit_if.unit u
);

	logic [$clog2(fan_out)-1:0] count;
	logic signed [bp_fixed_pkg::acc_w-1:0] acc;
	logic signed [bp_fixed_pkg::acc_w-1:0] product;
	logic signed [bp_fixed_pkg::acc_w-1:0] sum_next;
	logic last_term;

	// q4.12 times q4.12 gives q8.24, shifted back to 12 fraction bits.
	always_comb begin
		product = u.operand_a * u.operand_b;
		sum_next = acc + (product >>> bp_fixed_pkg::frac_w);
		last_term = (count == $bits(count)'(fan_out - 1));
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
			acc <= '0;
			u.result_valid <= 1'b0;
		end else begin
			u.result_valid <= 1'b0;
			if (u.valid) begin
				if (last_term) begin
					// node complete, start the next one from zero.
					count <= '0;
					acc <= '0;
					u.result_valid <= 1'b1;
				end else begin
					count <= count + 1'b1;
					acc <= sum_next;
				end
			end
		end
	end

	// the sum saturates only once, when it leaves.
	always_ff @(posedge clk) begin
		if (u.valid && last_term) begin
			u.result <= bp_fixed_pkg::sat_word(sum_next);
		end
	end

endmodule

/* source/bp_output_error.sv */
`timescale 1ns/1ps

module bp_output_error (
	input logic clk,
	input logic rst_n,
	bp_unit_if.unit u
);

	// one extra bit keeps target minus activation exact.
	logic signed [bp_fixed_pkg::word_w:0] diff;

	always_comb begin
		diff = u.operand_a - u.operand_b;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			u.result_valid <= 1'b0;
		end else begin
			u.result_valid <= u.valid;
		end
	end

	// the error is clamped back into one word.
	always_ff @(posedge clk) begin
		if (u.valid) begin
			u.result <= bp_fixed_pkg::sat_word(diff);
		end
	end

endmodule

/* source/bp_unit_if.sv */
`timescale 1ns/1ps

interface bp_unit_if;

	// operand side, driven by the sequencer.
	logic valid;
	logic signed [bp_fixed_pkg::word_w-1:0] operand_a;
	logic signed [bp_fixed_pkg::word_w-1:0] operand_b;

	// result side, one strobe per result.
	logic result_valid;
	logic signed [bp_fixed_pkg::word_w-1:0] result;

	modport seq (
		output valid,
		output operand_a,
		output operand_b,
		input  result_valid,
		input  result
	);

	modport unit (
		input  valid,
		input  operand_a,
		input  operand_b,
		output result_valid,
		output result
	);

endinterface

/* source/bp_net_pkg.sv */
package bp_net_pkg;

	// node counts per layer.
	localparam int n_out = 3;
	localparam int n_hid2 = 4;
	localparam int n_hid1 = 4;

	// one input burst carries the output targets and activations,
	// then the hidden-2 activations, then the hidden-1 activations.
	localparam int n_sample = n_out + n_hid2 + n_hid1;

	// node index width, sized for the largest layer.
	localparam int addr_w = 2;

	// width of the burst word counter, it has to reach n_sample.
	localparam int sample_w = $clog2(n_sample + 1);

	// layer code width.
	localparam int layer_w = 2;

	// layer codes.
	localparam logic [layer_w-1:0] layer_input = 2'd0;
	localparam logic [layer_w-1:0] layer_hid1 = 2'd1;
	localparam logic [layer_w-1:0] layer_hid2 = 2'd2;
	localparam logic [layer_w-1:0] layer_output = 2'd3;

endpackage

/* source/bp_fixed_pkg.sv */
package bp_fixed_pkg;

	// signed q4.12 words.
	localparam int word_w = 16;
	localparam int frac_w = 12;

	// accumulator for the hidden-layer sums.
	localparam int acc_w = 32;

	// alpha of the leaky relu is 2^-alpha_shift.
	localparam int alpha_shift = 3;

	// saturation limits of one word.
	localparam logic signed [word_w-1:0] word_max = 16'sh7fff;
	localparam logic signed [word_w-1:0] word_min = 16'sh8000;

	// clamps a wide signed value into one word.
	function automatic logic signed [word_w-1:0] sat_word(
		input logic signed [acc_w-1:0] value
	);
		logic signed [word_w-1:0] clamped;
		if (value > word_max) begin
			clamped = word_max;
		end else if (value < word_min) begin
			clamped = word_min;
		end else begin
			clamped = value[word_w-1:0];
		end
		return clamped;
	endfunction

endpackage
